//--- common/gprPkg.sv
// Register ID codes, field widths, lane tags and value typedefs
`default_nettype none

package gprPkg;

	// Field widths
	localparam int regIdWidth = 6;
	localparam int regValWidth = 64;
	localparam int immWidth = 33;	// Bit 32 is the sign
	localparam int gprIdxWidth = 5;
	localparam int laneTagWidth = 2;

	localparam int gprCount = 32;	// Architectural GPRs per bank

	typedef logic [regIdWidth-1:0] regIdT;
	typedef logic [regValWidth-1:0] regValT;
	typedef logic [immWidth-1:0] immValT;
	typedef logic [gprIdxWidth-1:0] gprIdxT;
	typedef logic [laneTagWidth-1:0] laneTagT;

	// Special register codes, just above the GPRs
	localparam regIdT regIdDlr = 6'd32;
	localparam regIdT regIdDhr = 6'd33;
	localparam regIdT regIdSp = 6'd34;

	// Constant sources
	localparam regIdT regIdImm = 6'd60;	// Lane immediate
	localparam regIdT regIdZzr = 6'd63;	// Reads zero, also "no write" as a dest

	// Bank that holds the newest copy of a GPR
	localparam laneTagT laneA = 2'd0;
	localparam laneTagT laneB = 2'd1;
	localparam laneTagT laneC = 2'd2;

endpackage

`default_nettype wire

//--- regfile/gprBank.sv
// One 32x64 GPR bank, single write port, six combinational read ports
`timescale 1ns/1ns
`default_nettype none

module gprBank
(
	input wire clock,
	input wire writeEn,	// Lane write, already qualified by hold/flush
	input wire gprPkg::gprIdxT writeIdx,
	input wire gprPkg::regValT writeVal,

	input wire gprPkg::gprIdxT readIdx0,	// Rs
	input wire gprPkg::gprIdxT readIdx1,	// Rt
	input wire gprPkg::gprIdxT readIdx2,	// Ru
	input wire gprPkg::gprIdxT readIdx3,	// Rv
	input wire gprPkg::gprIdxT readIdx4,	// Rx
	input wire gprPkg::gprIdxT readIdx5,	// Ry

	output gprPkg::regValT readVal0,
	output gprPkg::regValT readVal1,
	output gprPkg::regValT readVal2,
	output gprPkg::regValT readVal3,
	output gprPkg::regValT readVal4,
	output gprPkg::regValT readVal5
);

	// Bank storage, contents undefined until written
	gprPkg::regValT mem [gprPkg::gprCount];

	always_ff @(posedge clock)
	begin
		if (writeEn)
			mem[writeIdx] <= writeVal;
	end

	// Async reads, no bypass of same-cycle write
	assign readVal0 = mem[readIdx0];
	assign readVal1 = mem[readIdx1];
	assign readVal2 = mem[readIdx2];
	assign readVal3 = mem[readIdx3];
	assign readVal4 = mem[readIdx4];
	assign readVal5 = mem[readIdx5];

endmodule

`default_nettype wire

//--- regfile/gprBankedFile.sv
// Three per-lane GPR banks with lane table, write decode and six-way read select
`timescale 1ns/1ns
`default_nettype none

module gprBankedFile
(
	input wire clock,
	input wire rstN,
	input wire writeEn,	// Low under hold or EX3 flush

	input wire gprPkg::regIdT idA,	// EX3 dest IDs
	input wire gprPkg::regIdT idB,
	input wire gprPkg::regIdT idC,
	input wire gprPkg::regValT valA,	// EX3 results
	input wire gprPkg::regValT valB,
	input wire gprPkg::regValT valC,

	input wire gprPkg::regIdT readId0,
	input wire gprPkg::regIdT readId1,
	input wire gprPkg::regIdT readId2,
	input wire gprPkg::regIdT readId3,
	input wire gprPkg::regIdT readId4,
	input wire gprPkg::regIdT readId5,

	output gprPkg::regValT gprVal0,
	output gprPkg::regValT gprVal1,
	output gprPkg::regValT gprVal2,
	output gprPkg::regValT gprVal3,
	output gprPkg::regValT gprVal4,
	output gprPkg::regValT gprVal5
);

	logic hitA;	// Lane targets a GPR
	logic hitB;
	logic hitC;
	gprPkg::laneTagT laneTag [gprPkg::gprCount];	// Newest bank per GPR
	gprPkg::gprIdxT readIdx [6];
	gprPkg::regValT bankAVal [6];
	gprPkg::regValT bankBVal [6];
	gprPkg::regValT bankCVal [6];
	gprPkg::regValT selVal [6];

	// IDs 0-31 are GPRs, everything above is handled elsewhere or dropped
	assign hitA = (idA < gprPkg::regIdT'(gprPkg::gprCount));
	assign hitB = (idB < gprPkg::regIdT'(gprPkg::gprCount));
	assign hitC = (idC < gprPkg::regIdT'(gprPkg::gprCount));

	// Lane table, later assignment wins so C > B > A
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < gprPkg::gprCount; i++)
				laneTag[i] <= gprPkg::laneA;
		end
		else if (writeEn)
		begin
			if (hitA)
				laneTag[idA[4:0]] <= gprPkg::laneA;
			if (hitB)
				laneTag[idB[4:0]] <= gprPkg::laneB;
			if (hitC)
				laneTag[idC[4:0]] <= gprPkg::laneC;
		end
	end

	assign readIdx[0] = readId0[4:0];
	assign readIdx[1] = readId1[4:0];
	assign readIdx[2] = readId2[4:0];
	assign readIdx[3] = readId3[4:0];
	assign readIdx[4] = readId4[4:0];
	assign readIdx[5] = readId5[4:0];

	// Each bank writes independently, the tag sorts out conflicts
	gprBank bankA
	(
		.clock(clock),
		.writeEn(writeEn && hitA),
		.writeIdx(idA[4:0]),
		.writeVal(valA),
		.readIdx0(readIdx[0]),
		.readIdx1(readIdx[1]),
		.readIdx2(readIdx[2]),
		.readIdx3(readIdx[3]),
		.readIdx4(readIdx[4]),
		.readIdx5(readIdx[5]),
		.readVal0(bankAVal[0]),
		.readVal1(bankAVal[1]),
		.readVal2(bankAVal[2]),
		.readVal3(bankAVal[3]),
		.readVal4(bankAVal[4]),
		.readVal5(bankAVal[5])
	);

	gprBank bankB
	(
		.clock(clock),
		.writeEn(writeEn && hitB),
		.writeIdx(idB[4:0]),
		.writeVal(valB),
		.readIdx0(readIdx[0]),
		.readIdx1(readIdx[1]),
		.readIdx2(readIdx[2]),
		.readIdx3(readIdx[3]),
		.readIdx4(readIdx[4]),
		.readIdx5(readIdx[5]),
		.readVal0(bankBVal[0]),
		.readVal1(bankBVal[1]),
		.readVal2(bankBVal[2]),
		.readVal3(bankBVal[3]),
		.readVal4(bankBVal[4]),
		.readVal5(bankBVal[5])
	);

	gprBank bankC
	(
		.clock(clock),
		.writeEn(writeEn && hitC),
		.writeIdx(idC[4:0]),
		.writeVal(valC),
		.readIdx0(readIdx[0]),
		.readIdx1(readIdx[1]),
		.readIdx2(readIdx[2]),
		.readIdx3(readIdx[3]),
		.readIdx4(readIdx[4]),
		.readIdx5(readIdx[5]),
		.readVal0(bankCVal[0]),
		.readVal1(bankCVal[1]),
		.readVal2(bankCVal[2]),
		.readVal3(bankCVal[3]),
		.readVal4(bankCVal[4]),
		.readVal5(bankCVal[5])
	);

	// Pick the bank named by the tag, unused code 3 falls back to A
	for (genvar i = 0; i < 6; i++)
	begin : gReadSel
		assign selVal[i] = (laneTag[readIdx[i]] == gprPkg::laneC) ? bankCVal[i] :
			(laneTag[readIdx[i]] == gprPkg::laneB) ? bankBVal[i] : bankAVal[i];
	end

	assign gprVal0 = selVal[0];
	assign gprVal1 = selVal[1];
	assign gprVal2 = selVal[2];
	assign gprVal3 = selVal[3];
	assign gprVal4 = selVal[4];
	assign gprVal5 = selVal[5];

endmodule

`default_nettype wire

//--- source/sprBank.sv
// DLR, DHR and SP special registers with three-lane write priority
`timescale 1ns/1ns
`default_nettype none

module sprBank
(
	input wire clock,
	input wire rstN,
	input wire writeEn,	// Same gate as the GPR banks

	input wire gprPkg::regIdT idA,	// EX3 dest IDs
	input wire gprPkg::regIdT idB,
	input wire gprPkg::regIdT idC,
	input wire gprPkg::regValT valA,
	input wire gprPkg::regValT valB,
	input wire gprPkg::regValT valC,

	output gprPkg::regValT valDlr,
	output gprPkg::regValT valDhr,
	output gprPkg::regValT valSp
);

	// Next value for one register, C checked last so it wins
	function automatic gprPkg::regValT sprNext
	(
		input gprPkg::regIdT code,
		input gprPkg::regValT cur
	);
		gprPkg::regValT pick;
		pick = cur;	// Keep old value if no lane hits
		if (idA == code)
			pick = valA;
		if (idB == code)
			pick = valB;
		if (idC == code)
			pick = valC;
		return pick;
	endfunction

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			valDlr <= '0;
			valDhr <= '0;
			valSp <= '0;
		end
		else if (writeEn)
		begin
			valDlr <= sprNext(gprPkg::regIdDlr, valDlr);
			valDhr <= sprNext(gprPkg::regIdDhr, valDhr);
			valSp <= sprNext(gprPkg::regIdSp, valSp);	// Stack pointer
		end
	end

endmodule

`default_nettype wire

//--- source/operandPort.sv
// One operand read port with source select and EX1-EX3 forwarding
`timescale 1ns/1ns
`default_nettype none

module operandPort
(
	input wire gprPkg::regIdT srcId,
	input wire gprPkg::immValT imm,	// This port's lane immediate
	input wire gprPkg::regValT gprVal,	// Bank value picked by lane tag
	input wire gprPkg::regValT valDlr,
	input wire gprPkg::regValT valDhr,
	input wire gprPkg::regValT valSp,

	input wire gprPkg::regIdT idRnA1,	// EX1 dests
	input wire gprPkg::regValT valRnA1,
	input wire gprPkg::regIdT idRnB1,
	input wire gprPkg::regValT valRnB1,
	input wire gprPkg::regIdT idRnC1,
	input wire gprPkg::regValT valRnC1,
	input wire gprPkg::regIdT idRnA2,	// EX2 dests
	input wire gprPkg::regValT valRnA2,
	input wire gprPkg::regIdT idRnB2,
	input wire gprPkg::regValT valRnB2,
	input wire gprPkg::regIdT idRnC2,
	input wire gprPkg::regValT valRnC2,
	input wire gprPkg::regIdT idRnA3,	// EX3 dests, also the write lanes
	input wire gprPkg::regValT valRnA3,
	input wire gprPkg::regIdT idRnB3,
	input wire gprPkg::regValT valRnB3,
	input wire gprPkg::regIdT idRnC3,
	input wire gprPkg::regValT valRnC3,

	output gprPkg::regValT srcVal
);

	gprPkg::regValT baseVal;	// Value from stored state or constant
	logic isConst;	// Imm and ZZR never forward

	// Base value select
	always_comb
	begin
		isConst = 1'b0;
		if (srcId < gprPkg::regIdT'(gprPkg::gprCount))
			baseVal = gprVal;
		else
		begin
			case (srcId)
				gprPkg::regIdDlr:
					baseVal = valDlr;
				gprPkg::regIdDhr:
					baseVal = valDhr;
				gprPkg::regIdSp:
					baseVal = valSp;
				gprPkg::regIdImm:
				begin
					baseVal = {{31{imm[32]}}, imm};	// Sign-extend 33 to 64
					isConst = 1'b1;
				end
				gprPkg::regIdZzr:
				begin
					baseVal = '0;
					isConst = 1'b1;
				end
				default:
					baseVal = '0;	// Unmapped code, still forwardable
			endcase
		end
	end

	// Youngest stage first, lane A first within a stage
	always_comb
	begin
		srcVal = baseVal;
		if (!isConst)
		begin
			if (srcId == idRnA1)
				srcVal = valRnA1;
			else if (srcId == idRnB1)
				srcVal = valRnB1;
			else if (srcId == idRnC1)
				srcVal = valRnC1;
			else if (srcId == idRnA2)
				srcVal = valRnA2;
			else if (srcId == idRnB2)
				srcVal = valRnB2;
			else if (srcId == idRnC2)
				srcVal = valRnC2;
			else if (srcId == idRnA3)	// EX3 forwards even when flushed
				srcVal = valRnA3;
			else if (srcId == idRnB3)
				srcVal = valRnB3;
			else if (srcId == idRnC3)
				srcVal = valRnC3;
		end
	end

endmodule

`default_nettype wire

//--- source/gprTop.sv
// Register file top with banked GPRs, special registers and six operand ports
`timescale 1ns/1ns
`default_nettype none

module gprTop
(
	input wire clock,
	input wire rstN,
	input wire hold,	// Pipeline stall, freezes all state
	input wire ex3Flush,	// EX3 results are dead

	input wire gprPkg::regIdT idRs,	// Lane 1 sources
	input wire gprPkg::regIdT idRt,
	input wire gprPkg::regIdT idRu,	// Lane 2 sources
	input wire gprPkg::regIdT idRv,
	input wire gprPkg::regIdT idRx,	// Lane 3 sources
	input wire gprPkg::regIdT idRy,

	input wire gprPkg::immValT immA,	// Decode immediates per lane
	input wire gprPkg::immValT immB,
	input wire gprPkg::immValT immC,

	input wire gprPkg::regIdT idRnA1,
	input wire gprPkg::regValT valRnA1,
	input wire gprPkg::regIdT idRnB1,
	input wire gprPkg::regValT valRnB1,
	input wire gprPkg::regIdT idRnC1,
	input wire gprPkg::regValT valRnC1,
	input wire gprPkg::regIdT idRnA2,
	input wire gprPkg::regValT valRnA2,
	input wire gprPkg::regIdT idRnB2,
	input wire gprPkg::regValT valRnB2,
	input wire gprPkg::regIdT idRnC2,
	input wire gprPkg::regValT valRnC2,
	input wire gprPkg::regIdT idRnA3,	// Write lanes
	input wire gprPkg::regValT valRnA3,
	input wire gprPkg::regIdT idRnB3,
	input wire gprPkg::regValT valRnB3,
	input wire gprPkg::regIdT idRnC3,
	input wire gprPkg::regValT valRnC3,

	output gprPkg::regValT valRs,
	output gprPkg::regValT valRt,
	output gprPkg::regValT valRu,
	output gprPkg::regValT valRv,
	output gprPkg::regValT valRx,
	output gprPkg::regValT valRy
);

	logic writeEn;
	gprPkg::regValT gprValRs;	// Stored GPR per port
	gprPkg::regValT gprValRt;
	gprPkg::regValT gprValRu;
	gprPkg::regValT gprValRv;
	gprPkg::regValT gprValRx;
	gprPkg::regValT gprValRy;
	gprPkg::regValT valDlr;
	gprPkg::regValT valDhr;
	gprPkg::regValT valSp;

	assign writeEn = !hold && !ex3Flush;	// Both block every lane

	gprBankedFile bankedFile
	(
		.clock(clock),
		.rstN(rstN),
		.writeEn(writeEn),
		.idA(idRnA3),
		.idB(idRnB3),
		.idC(idRnC3),
		.valA(valRnA3),
		.valB(valRnB3),
		.valC(valRnC3),
		.readId0(idRs),
		.readId1(idRt),
		.readId2(idRu),
		.readId3(idRv),
		.readId4(idRx),
		.readId5(idRy),
		.gprVal0(gprValRs),
		.gprVal1(gprValRt),
		.gprVal2(gprValRu),
		.gprVal3(gprValRv),
		.gprVal4(gprValRx),
		.gprVal5(gprValRy)
	);

	sprBank specialRegs
	(
		.clock(clock),
		.rstN(rstN),
		.writeEn(writeEn),
		.idA(idRnA3),
		.idB(idRnB3),
		.idC(idRnC3),
		.valA(valRnA3),
		.valB(valRnB3),
		.valC(valRnC3),
		.valDlr(valDlr),
		.valDhr(valDhr),
		.valSp(valSp)
	);

	// Dest pairs and special registers connect by name
	operandPort portRs (.*, .srcId(idRs), .imm(immA), .gprVal(gprValRs), .srcVal(valRs));
	operandPort portRt (.*, .srcId(idRt), .imm(immA), .gprVal(gprValRt), .srcVal(valRt));
	operandPort portRu (.*, .srcId(idRu), .imm(immB), .gprVal(gprValRu), .srcVal(valRu));
	operandPort portRv (.*, .srcId(idRv), .imm(immB), .gprVal(gprValRv), .srcVal(valRv));
	operandPort portRx (.*, .srcId(idRx), .imm(immC), .gprVal(gprValRx), .srcVal(valRx));
	operandPort portRy (.*, .srcId(idRy), .imm(immC), .gprVal(gprValRy), .srcVal(valRy));

endmodule

`default_nettype wire

//--- verif/gprTopTb.sv
// Random testbench for gprTop with register file model, forwarding model and checker
`timescale 1ns/1ns
`default_nettype none

module gprTopTb;

	logic clock;
	logic rstN;
	logic hold;
	logic ex3Flush;
	gprPkg::regIdT srcId [6];	// Rs, Rt, Ru, Rv, Rx, Ry
	gprPkg::immValT immVal [3];	// Lanes A, B, C
	gprPkg::regIdT destId [9];	// A1 B1 C1 A2 B2 C2 A3 B3 C3
	gprPkg::regValT destVal [9];
	gprPkg::regValT valRs;
	gprPkg::regValT valRt;
	gprPkg::regValT valRu;
	gprPkg::regValT valRv;
	gprPkg::regValT valRx;
	gprPkg::regValT valRy;

	// Reference state
	gprPkg::regValT modelGpr [32];
	logic gprWritten [32];	// GPR has a defined value
	gprPkg::regValT modelDlr;
	gprPkg::regValT modelDhr;
	gprPkg::regValT modelSp;
	integer seed;
	int cycles;
	int lanes;
	gprPkg::regIdT target;

	always #4 clock = ~clock;	// 8 ns period

	gprTop UUT
	(
		.clock(clock), .rstN(rstN), .hold(hold), .ex3Flush(ex3Flush),
		.idRs(srcId[0]), .idRt(srcId[1]), .idRu(srcId[2]),
		.idRv(srcId[3]), .idRx(srcId[4]), .idRy(srcId[5]),
		.immA(immVal[0]), .immB(immVal[1]), .immC(immVal[2]),
		.idRnA1(destId[0]), .valRnA1(destVal[0]), .idRnB1(destId[1]), .valRnB1(destVal[1]),
		.idRnC1(destId[2]), .valRnC1(destVal[2]), .idRnA2(destId[3]), .valRnA2(destVal[3]),
		.idRnB2(destId[4]), .valRnB2(destVal[4]), .idRnC2(destId[5]), .valRnC2(destVal[5]),
		.idRnA3(destId[6]), .valRnA3(destVal[6]), .idRnB3(destId[7]), .valRnB3(destVal[7]),
		.idRnC3(destId[8]), .valRnC3(destVal[8]),
		.valRs(valRs), .valRt(valRt), .valRu(valRu),
		.valRv(valRv), .valRx(valRx), .valRy(valRy)
	);

	function automatic gprPkg::regValT randomValue();
		return {$random(seed), $random(seed)};
	endfunction

	// Small ID pool so sources and dests collide often
	function automatic gprPkg::regIdT poolId();
		int r;
		gprPkg::regIdT id;
		r = $unsigned($random(seed)) % 14;
		case (r)
			8: id = gprPkg::regIdDlr;
			9: id = gprPkg::regIdDhr;
			10: id = gprPkg::regIdSp;
			11: id = gprPkg::regIdImm;
			12: id = gprPkg::regIdZzr;
			13: id = 6'd45;	// Unmapped code
			default: id = gprPkg::regIdT'(r);	// GPR 0-7
		endcase
		return id;
	endfunction

	// Source with a defined stored value
	function automatic gprPkg::regIdT storedId();
		int r;
		r = $unsigned($random(seed)) % 35;	// 32-34 are DLR, DHR, SP
		if (r < 32 && !gprWritten[r])
			return gprPkg::regIdZzr;
		return gprPkg::regIdT'(r);
	endfunction

	// Number of GPRs the model holds a value for
	function automatic int writtenCount();
		int n;
		n = 0;
		for (int g = 0; g < 32; g++)
			if (gprWritten[g])
				n++;
		return n;
	endfunction

	// Expected port value from the source table and forwarding order
	function automatic gprPkg::regValT expectRead(input gprPkg::regIdT src,
		input gprPkg::immValT imm);
		gprPkg::regValT result;
		logic isConst;
		logic found;
		result = '0;
		isConst = 1'b0;
		found = 1'b0;
		if (src < 6'd32)
			result = modelGpr[src[4:0]];
		else if (src == gprPkg::regIdDlr)
			result = modelDlr;
		else if (src == gprPkg::regIdDhr)
			result = modelDhr;
		else if (src == gprPkg::regIdSp)
			result = modelSp;
		else if (src == gprPkg::regIdImm)
		begin
			result = gprPkg::regValT'($signed(imm));
			isConst = 1'b1;
		end
		else if (src == gprPkg::regIdZzr)
			isConst = 1'b1;
		for (int k = 0; k < 9; k++)	// EX1 to EX3 and A to C within a stage
		begin
			if (!isConst && !found && destId[k] == src)
			begin
				result = destVal[k];
				found = 1'b1;
			end
		end
		return result;
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input gprPkg::regValT actual,
		input gprPkg::regValT expected);
		if (actual !== expected)
			abortRun($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
	endtask

	task automatic checkPorts();
		checkValue("valRs", valRs, expectRead(srcId[0], immVal[0]));
		checkValue("valRt", valRt, expectRead(srcId[1], immVal[0]));
		checkValue("valRu", valRu, expectRead(srcId[2], immVal[1]));
		checkValue("valRv", valRv, expectRead(srcId[3], immVal[1]));
		checkValue("valRx", valRx, expectRead(srcId[4], immVal[2]));
		checkValue("valRy", valRy, expectRead(srcId[5], immVal[2]));
	endtask

	// EX3 lane write into the model
	task automatic commitLane(input gprPkg::regIdT id, input gprPkg::regValT val);
		if (id < 6'd32)
		begin
			modelGpr[id[4:0]] = val;
			gprWritten[id[4:0]] = 1'b1;
		end
		else if (id == gprPkg::regIdDlr)
			modelDlr = val;
		else if (id == gprPkg::regIdDhr)
			modelDhr = val;
		else if (id == gprPkg::regIdSp)
			modelSp = val;
	endtask

	// Model update on the rising edge and return to the falling edge
	task automatic finishCycle();
		@(posedge clock);
		if (!rstN)
		begin
			modelDlr = '0;
			modelDhr = '0;
			modelSp = '0;
		end
		else if (!hold && !ex3Flush)
		begin
			commitLane(destId[6], destVal[6]);	// A first so C wins
			commitLane(destId[7], destVal[7]);
			commitLane(destId[8], destVal[8]);
		end
		@(negedge clock);
	endtask

	task automatic stepCycle();
		#3;	// Just before the rising edge
		checkPorts();
		finishCycle();
	endtask

	task automatic quietInputs();
		hold = 1'b0;
		ex3Flush = 1'b0;
		for (int p = 0; p < 6; p++)
			srcId[p] = gprPkg::regIdZzr;
		for (int k = 0; k < 9; k++)
		begin
			destId[k] = gprPkg::regIdZzr;
			destVal[k] = randomValue();
		end
		for (int l = 0; l < 3; l++)
			immVal[l] = gprPkg::immValT'(randomValue());
	endtask

	task automatic randomInputs();
		quietInputs();
		for (int p = 0; p < 6; p++)
			srcId[p] = poolId();
		for (int k = 0; k < 9; k++)
			destId[k] = poolId();
	endtask

	initial
	begin
		seed = 32'h2e4cec08;
		clock = 1'b1;	// First edge is a falling one
		rstN = 1'b0;
		for (int g = 0; g < 32; g++)
		begin
			modelGpr[g] = '0;
			gprWritten[g] = 1'b0;
		end
		modelDlr = '0;
		modelDhr = '0;
		modelSp = '0;
		quietInputs();
		@(negedge clock);
		repeat (8)
			finishCycle();
		rstN = 1'b1;

		// Special registers read zero after reset
		srcId[0] = gprPkg::regIdDlr;
		srcId[1] = gprPkg::regIdDhr;
		srcId[2] = gprPkg::regIdSp;
		srcId[3] = gprPkg::regIdDlr;
		srcId[4] = gprPkg::regIdDhr;
		srcId[5] = gprPkg::regIdSp;
		#3;
		checkValue("valRs", valRs, 64'h0);
		checkValue("valRt", valRt, 64'h0);
		checkValue("valRu", valRu, 64'h0);
		checkValue("valRv", valRv, 64'h0);
		checkValue("valRx", valRx, 64'h0);
		checkValue("valRy", valRy, 64'h0);
		finishCycle();

		// Fill every GPR through random lanes
		cycles = 0;
		while (writtenCount() < 32)
		begin
			if (cycles >= 200)
				abortRun("Timeout: not every GPR was written within 200 cycles");
			quietInputs();
			for (int k = 6; k < 9; k++)
				destId[k] = gprPkg::regIdT'($unsigned($random(seed)) % 32);
			for (int p = 0; p < 6; p++)
				srcId[p] = storedId();
			stepCycle();
			cycles++;
		end

		// Two or three EX3 lanes on one register and a read-back cycle
		repeat (40)
		begin
			quietInputs();
			if ($unsigned($random(seed)) % 4 == 0)
				target = gprPkg::regIdT'(32 + $unsigned($random(seed)) % 3);
			else
				target = gprPkg::regIdT'($unsigned($random(seed)) % 32);
			lanes = $unsigned($random(seed)) % 4;	// AB, BC, AC, ABC
			destId[6] = (lanes != 1) ? target : gprPkg::regIdZzr;
			destId[7] = (lanes != 2) ? target : gprPkg::regIdZzr;
			destId[8] = (lanes != 0) ? target : gprPkg::regIdZzr;
			for (int p = 0; p < 6; p++)
				srcId[p] = storedId();
			stepCycle();
			quietInputs();
			for (int p = 0; p < 6; p++)
				srcId[p] = target;
			stepCycle();
		end

		// Constant sources against matching dest IDs
		repeat (40)
		begin
			randomInputs();
			destId[$unsigned($random(seed)) % 9] = gprPkg::regIdImm;
			destId[$unsigned($random(seed)) % 9] = gprPkg::regIdZzr;
			for (int p = 0; p < 6; p++)
				srcId[p] = ($random(seed) & 1) ? gprPkg::regIdImm : gprPkg::regIdZzr;
			stepCycle();
		end

		// Forwarding priority with random dests
		repeat (200)
		begin
			randomInputs();
			stepCycle();
		end

		// Hold or flush and a read of the blocked targets
		repeat (40)
		begin
			randomInputs();
			lanes = $unsigned($random(seed)) % 3;
			hold = (lanes != 1);
			ex3Flush = (lanes != 0);
			stepCycle();
			for (int p = 0; p < 6; p++)
				srcId[p] = destId[6 + p % 3];
			for (int k = 0; k < 9; k++)
				destId[k] = gprPkg::regIdZzr;
			hold = 1'b0;
			ex3Flush = 1'b0;
			stepCycle();
		end

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- gprTop.f
common/gprPkg.sv
regfile/gprBank.sv
regfile/gprBankedFile.sv
source/sprBank.sv
source/operandPort.sv
source/gprTop.sv
verif/gprTopTb.sv

//--- Bender.yml
package:
  name: gprTop

sources:
  - common/gprPkg.sv
  - regfile/gprBank.sv
  - regfile/gprBankedFile.sv
  - source/sprBank.sv
  - source/operandPort.sv
  - source/gprTop.sv
  - target: simulation
    files:
      - verif/gprTopTb.sv
